// ==== Bender.yml ====
package:
  name: trace_back_decoder

sources:
  # shared package first, then the stages, then the top level
  - hw/trellisPkg.sv
  - hw/survivorHistory.sv
  - hw/traceBackWalker.sv
  - hw/decisionOutput.sv
  - hw/traceBackDecoder.sv
  - target: simulation
    files:
      - testbench/traceBackDecoderTb.sv

// ==== hw/decisionOutput.sv ====
// strobe and phase delay line, final decision register
`timescale 1ns/1ps

module decisionOutput (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      symEn,      // one-cycle symbol strobe
   input  logic                      pairPhase,  // high before the even strobe
   input  trellisPkg::decisionPairT  decisions,  // both decisions of the last walk
   output logic                      decision,   // hard decision, one per strobe
   output logic                      symEnDly    // symEn delayed by outDelay
);
   import trellisPkg::*;

   logic [outDelay-1:0] symEnSr;   // strobe delay line
   logic [outDelay-1:0] phaseSr;   // phase delay line, same length
   logic                phaseDly;

   // ----------------------------------------
   // delay lines
   // ----------------------------------------
   // the phase entering the line is the one a strobe leaves behind:
   // low after the even strobe, high after the odd one
   always_ff @(posedge clk) begin
      if (reset) begin
         symEnSr <= '0;
         phaseSr <= '0;
      end
      else begin
         symEnSr <= {symEnSr[outDelay-2:0], symEn};
         phaseSr <= {phaseSr[outDelay-2:0], pairPhase ^ symEn};
      end
   end

   assign symEnDly = symEnSr[outDelay-1];
   assign phaseDly = phaseSr[outDelay-1];

   // ----------------------------------------
   // final decision
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         decision <= 1'b0;
      end
      else if (symEnDly) begin
         // even strobe of the pair gives first, odd strobe gives second
         decision <= phaseDly ? decisions.second : decisions.first;
      end
   end

   // a one-cycle strobe in must stay a one-cycle pulse out
   dlyPulse: assert property (
      @(posedge clk) disable iff (reset) symEnDly |=> !symEnDly
   ) else $error("symEnDly high on two consecutive cycles");

endmodule

// ==== hw/survivorHistory.sv ====
// survivor-select shift registers and strobe pair phase
`timescale 1ns/1ps

module survivorHistory (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      symEn,     // one-cycle symbol strobe
   input  trellisPkg::selVecT        sel,       // 0 -> +7, 1 -> -7 per state
   output trellisPkg::survivorHistT  hist,      // full trace-back table
   output logic                      pairPhase  // high before the even strobe of a pair
);
   import trellisPkg::*;

   // ----------------------------------------
   // trace-back table
   // ----------------------------------------
   // every row moves one symbol deeper on a strobe
   always_ff @(posedge clk) begin
      if (reset) begin
         hist <= '0;                          // whole table cleared
      end
      else if (symEn) begin
         for (int s = 0; s < numStates; s++) begin
            // oldest bit drops off the top, newest select enters at bit 0
            hist[s] <= {hist[s][traceDepth-1:0], sel[s]};
         end
      end
   end

   // ----------------------------------------
   // strobe pair phase
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         pairPhase <= 1'b1;                   // first strobe after reset is even
      end
      else if (symEn) begin
         pairPhase <= ~pairPhase;             // flips once per strobe
      end
   end

   // ----------------------------------------
   // checks
   // ----------------------------------------
   // slow strobe mode only: the walk started by one strobe must finish
   // before the table shifts again, so strobes sit traceDepth+2 clocks apart
   // or more
   strobeSpacing: assert property (
      @(posedge clk) disable iff (reset)
         symEn |=> !symEn [*traceDepth+1]
   ) else $error("symEn strobes closer than %0d cycles", traceDepth + 2);

endmodule

// ==== hw/traceBackDecoder.sv ====
// trace-back decoder top, history, walker and output stages
`timescale 1ns/1ps

module traceBackDecoder (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 symEn,     // symbol strobe, slow mode spacing
   input  trellisPkg::selVecT   sel,       // survivor selects for this symbol
   input  trellisPkg::stateIdxT index,     // best metric state
   output logic                 decision,  // hard decision out
   output logic                 symEnDly   // marks a new decision
);
   import trellisPkg::*;

   survivorHistT hist;        // trace-back table
   logic         pairPhase;   // even / odd strobe of the pair
   decisionPairT decisions;   // two decisions per walk

   // input side, stores one select bit per state per strobe
   survivorHistory survivorHistory_inst (
      .clk       (clk),
      .reset     (reset),
      .symEn     (symEn),
      .sel       (sel),
      .hist      (hist),
      .pairPhase (pairPhase)
   );

   // walks back traceDepth symbols on every even strobe
   traceBackWalker traceBackWalker_inst (
      .clk       (clk),
      .reset     (reset),
      .symEn     (symEn),
      .pairPhase (pairPhase),
      .index     (index),
      .hist      (hist),
      .decisions (decisions)
   );

   // fixed latency output, one decision per strobe
   decisionOutput decisionOutput_inst (
      .clk       (clk),
      .reset     (reset),
      .symEn     (symEn),
      .pairPhase (pairPhase),
      .decisions (decisions),
      .decision  (decision),
      .symEnDly  (symEnDly)
   );

endmodule

// ==== hw/traceBackWalker.sv ====
// trace-back walk FSM, state pointer stepping and capture of both decisions
`timescale 1ns/1ps

module traceBackWalker (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      symEn,      // one-cycle symbol strobe
   input  logic                      pairPhase,  // high -> this strobe is even
   input  trellisPkg::stateIdxT      index,      // state with the best metric
   input  trellisPkg::survivorHistT  hist,       // trace-back table
   output trellisPkg::decisionPairT  decisions   // held until the next walk
);
   import trellisPkg::*;

   typedef logic [$clog2(traceDepth)-1:0] stepCntT; // walk step 0..traceDepth-1

   walkStateT walkState;
   stateIdxT  statePtr;      // state currently visited by the walk
   stateIdxT  nextPtr;
   stepCntT   stepCnt;       // also the history depth read this cycle
   logic      startWalk;
   logic      curBit;        // select bit of the visited state at this depth
   logic [5:0] stepSum;      // pointer + 7 or + 13, up to 32 before the wrap

   // only the even strobe of a pair starts a walk
   assign startWalk = symEn & pairPhase;

   // ----------------------------------------
   // branch step
   // ----------------------------------------
   assign curBit  = hist[statePtr][stepCnt];
   // sel 0 moves +7, sel 1 moves -7 which is +13 modulo 20
   assign stepSum = {1'b0, statePtr}
                  + (curBit ? 6'(numStates - stateStep) : 6'(stateStep));
   assign nextPtr = (stepSum >= 6'(numStates)) ? stateIdxT'(stepSum - 6'(numStates))
                                               : stateIdxT'(stepSum);

   // ----------------------------------------
   // walk FSM and pointer
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         walkState <= walkIdle;
         stepCnt   <= '0;
         statePtr  <= '0;
      end
      else if (startWalk) begin
         walkState <= walkRun;
         stepCnt   <= '0;                     // begin at the newest history bit
         statePtr  <= index;                  // start from the best metric state
      end
      else if (walkState == walkRun) begin
         statePtr <= nextPtr;                 // one trellis branch per clock
         stepCnt  <= stepCnt + 1'b1;
         if (stepCnt == stepCntT'(traceDepth - 1)) begin
            walkState <= walkIdle;            // traceDepth steps taken
         end
      end
   end

   // ----------------------------------------
   // decision capture
   // ----------------------------------------
   // the bit read at the two deepest steps is the hard decision there
   always_ff @(posedge clk) begin
      if (reset) begin
         decisions <= '0;
      end
      else if ((walkState == walkRun) && !startWalk) begin
         if (stepCnt == stepCntT'(traceDepth - 2)) begin
            decisions.first <= curBit;        // depth traceDepth-2
         end
         else if (stepCnt == stepCntT'(traceDepth - 1)) begin
            decisions.second <= curBit;       // depth traceDepth-1
         end
      end
   end

   // ----------------------------------------
   // checks
   // ----------------------------------------
   // catches an out of range index from the metric unit as well as a bad wrap
   ptrInRange: assert property (
      @(posedge clk) disable iff (reset)
         statePtr < numStates
   ) else $error("trace-back pointer %0d out of range", statePtr);

endmodule

// ==== hw/trellisPkg.sv ====
// trellis sizes, history and state types, decision pair struct, walker FSM states
package trellisPkg;

   // ----------------------------------------
   // trellis sizes
   // ----------------------------------------
   localparam int numStates  = 20;            // trellis states
   localparam int stateStep  = 7;             // branch distance, + or - 7 modulo 20
   localparam int traceDepth = 8;             // history bits used by one walk
   localparam int outDelay   = traceDepth + 1; // strobe to symEnDly latency

   // ----------------------------------------
   // vector types
   // ----------------------------------------
   typedef logic [4:0]             stateIdxT; // trellis state number 0..19
   typedef logic [numStates-1:0]   selVecT;   // one select bit per state, one symbol
   typedef logic [traceDepth:0]    histRowT;  // select history of one state, bit 0 newest

   // whole trace-back table, 20 rows of 9 bits
   typedef histRowT [numStates-1:0] survivorHistT;

   // two hard decisions out of one walk
   // first comes from depth traceDepth-2, second from traceDepth-1
   typedef struct packed {
      logic first;
      logic second;
   } decisionPairT;

   // walker FSM
   typedef enum logic {
      walkIdle,   // walk done, pointer parked
      walkRun     // stepping back through the history
   } walkStateT;

endpackage

// ==== sim.f ====
hw/trellisPkg.sv
hw/survivorHistory.sv
hw/traceBackWalker.sv
hw/decisionOutput.sv
hw/traceBackDecoder.sv
testbench/traceBackDecoderTb.sv

// ==== testbench/traceBackDecoderTb.sv ====
// trace-back decoder testbench with clock, reset, vector file stimulus, checks and report
`timescale 1ns/1ps

module traceBackDecoderTb;
   import trellisPkg::*;

   localparam int numVectors    = 24;                  // strobe pairs in the vector file
   localparam int vecWords      = numVectors * 5;      // selA selB index first second
   localparam int phasePairs    = 6;                   // pairs per constant select run
   localparam int settlePairs   = traceDepth / 2;      // pairs until a walk sees only new selects
   localparam int numStrobes    = 2 * (numVectors + 2 * phasePairs);
   localparam int timeoutCycles = numStrobes * (traceDepth + 6) + 50;

   logic     clk = 1'b0;
   logic     reset;
   logic     symEn;
   selVecT   sel;
   stateIdxT index;
   logic     decision;
   logic     symEnDly;

   selVecT   vecMem [0:vecWords-1];   // flat copy of the vector file
   integer   seed        = 32'he10b;  // gap and index picks
   int       errors      = 0;
   int       checks      = 0;
   int       tests       = 0;
   int       dlyErrors   = 0;         // strobe delay errors only
   int       cycleCount  = 0;
   int       pulseCount  = 0;         // symEnDly pulses seen
   int       strobeCount = 0;         // symEn pulses sent
   logic [outDelay-1:0] strobeHist = '0;   // symEn at rising edges, bit 0 newest

   traceBackDecoder traceBackDecoder_inst (
      .clk      (clk),
      .reset    (reset),
      .symEn    (symEn),
      .sel      (sel),
      .index    (index),
      .decision (decision),
      .symEnDly (symEnDly)
   );

   // ----------------------------------------
   // clock, cycle limit, strobe monitor
   // ----------------------------------------
   initial begin
      forever #5 clk = ~clk;   // 10 ns period
   end

   always @(posedge clk) begin
      cycleCount++;
      if (cycleCount > timeoutCycles) begin
         $display("run stopped, no finish within %0d cycles", timeoutCycles);
         $display("Errors found");
         $finish;
      end
   end

   always @(posedge clk) begin
      strobeHist <= {strobeHist[outDelay-2:0], symEn};   // reference delay line
   end

   // symEnDly must mirror symEn outDelay cycles later, reset included
   always @(negedge clk) begin
      if (symEnDly === 1'b1) begin
         pulseCount++;
      end
      assert (symEnDly === strobeHist[outDelay-1]) else begin
         $display("[FAIL] strobeDelay at %0t: expected %b, actual %b",
                  $time, strobeHist[outDelay-1], symEnDly);
         errors++;
         dlyErrors++;
      end
   end

   // ----------------------------------------
   // helpers
   // ----------------------------------------
   task automatic checkBit(input string name, input logic expected, input logic actual);
      checks++;
      assert (actual === expected) else begin
         $display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
         errors++;
      end
   endtask

   task automatic reportTest(input string name, input int newErrors);
      tests++;
      if (newErrors == 0) begin
         $display("%-16s ok", name);
      end
      else begin
         $display("%-16s %0d errors", name, newErrors);
      end
   endtask

   // entered on a falling edge, leaves on the falling edge where the next strobe may go
   task automatic sendStrobe(input selVecT s, input stateIdxT idx, output logic got);
      int gap;
      int waited;
      gap   = traceDepth + 2 + ({$random(seed)} % 5);   // traceDepth+2 .. traceDepth+6
      symEn = 1'b1;
      sel   = s;
      index = idx;
      strobeCount++;
      @(negedge clk);
      symEn  = 1'b0;
      waited = 1;
      while (symEnDly !== 1'b1 && waited <= outDelay) begin
         @(negedge clk);
         waited++;
      end
      assert (symEnDly === 1'b1) else begin
         $display("no symEnDly pulse within %0d cycles of a strobe", outDelay + 1);
         errors++;
      end
      @(negedge clk);   // decision register took its value at the last rising edge
      waited++;
      got = decision;
      while (waited < gap) begin
         @(negedge clk);
         waited++;
      end
   endtask

   task automatic sendPair(input selVecT selA, input selVecT selB, input stateIdxT idx,
                           output logic gotFirst, output logic gotSecond);
      sendStrobe(selA, idx, gotFirst);    // even strobe, starts the walk
      sendStrobe(selB, idx, gotSecond);   // odd strobe
   endtask

   // constant selects, so once settled any bit a walk reads equals selBit
   task automatic runPhase(input string name, input logic selBit);
      logic     gotFirst;
      logic     gotSecond;
      stateIdxT idx;
      int       errBefore;
      errBefore = errors;
      for (int p = 0; p < phasePairs; p++) begin
         idx = stateIdxT'({$random(seed)} % numStates);   // any start state
         sendPair({numStates{selBit}}, {numStates{selBit}}, idx, gotFirst, gotSecond);
         if (p >= settlePairs) begin
            checkBit($sformatf("%s pair %0d first", name, p), selBit, gotFirst);
            checkBit($sformatf("%s pair %0d second", name, p), selBit, gotSecond);
         end
      end
      reportTest(name, errors - errBefore);
   endtask

   // ----------------------------------------
   // test sequence
   // ----------------------------------------
   initial begin
      string name;
      logic  gotFirst;
      logic  gotSecond;
      int    errBefore;
      int    missing;
      reset = 1'b1;
      symEn = 1'b0;
      sel   = '0;
      index = '0;
      $readmemh("testbench/traceBackVectors.txt", vecMem);

      // outputs held low in reset and just after it
      errBefore = errors;
      repeat (2) begin
         @(negedge clk);
         checkBit("reset decision", 1'b0, decision);
         checkBit("reset symEnDly", 1'b0, symEnDly);
      end
      reset = 1'b0;
      repeat (3) begin
         @(negedge clk);
         checkBit("post reset decision", 1'b0, decision);
         checkBit("post reset symEnDly", 1'b0, symEnDly);
      end
      reportTest("reset", errors - errBefore);

      missing = 0;
      for (int w = 0; w < vecWords; w++) begin
         if ($isunknown(vecMem[w])) begin
            missing++;
         end
      end
      assert (missing == 0) else begin
         $display("vector file has %0d missing or unreadable words", missing);
         errors++;
      end

      // file lines follow reset directly, history starts from zero
      for (int v = 0; v < numVectors; v++) begin
         errBefore = errors;
         name = $sformatf("vector %0d", v);
         sendPair(vecMem[5*v], vecMem[5*v+1], stateIdxT'(vecMem[5*v+2]), gotFirst, gotSecond);
         checkBit({name, " first"}, vecMem[5*v+3][0], gotFirst);
         checkBit({name, " second"}, vecMem[5*v+4][0], gotSecond);
         reportTest(name, errors - errBefore);
      end

      runPhase("zeroHistory", 1'b0);   // +7 branches only
      runPhase("oneHistory", 1'b1);    // -7 branches only

      // one symEnDly pulse per strobe, nothing extra
      assert (pulseCount == strobeCount) else begin
         $display("[FAIL] strobeDelay pulses: expected %0d, actual %0d", strobeCount, pulseCount);
         errors++;
         dlyErrors++;
      end
      reportTest("strobeDelay", dlyErrors);

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end
      else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// ==== testbench/traceBackVectors.txt ====
// selA selB index first second, all hex, one strobe pair per line counted from reset
// selA goes with the even strobe that starts the walk, selB with the odd strobe
5A3C1 0F0F0 03 0 0
A5C3E 12345 11 0 0
3C96A E1D2B 00 0 0
7B4E8 9F015 0B 0 0
2468A C3A5F 13 0 0
D6B37 4E1F2 06 0 0
8A9C4 17E6D 0E 0 1
B05F3 6DC29 08 1 0
35C9A CA365 02 1 1
35C9A CA365 0F 0 0
35C9A CA365 05 0 1
35C9A CA365 0C 0 1
35C9A CA365 00 1 0
35C9A CA365 07 0 1
35C9A CA365 0D 0 1
35C9A CA365 04 1 0
35C9A CA365 13 0 1
35C9A CA365 0A 1 0
35C9A CA365 01 1 0
35C9A CA365 10 0 1
35C9A CA365 09 1 0
35C9A CA365 06 0 1
35C9A CA365 03 1 0
35C9A CA365 12 0 1
